//--- logic/spi_dev_pkg.sv
// shared types and constants for the spi device-test block
// frame layout, register map indices and the request/response structs
// between the frame engine and the register block
package spi_dev_pkg;

    // widths with a meaning
    typedef logic [31:0] data_t;     // register data word
    typedef logic [5:0]  reg_idx_t;  // word index into the register map
    typedef logic [15:0] gpio_t;     // one bit per gpio pin
    typedef logic [5:0]  bit_cnt_t;  // counts 0..FRAME_BITS

    // first byte of every frame, msb first
    typedef struct packed {
        logic     write;  // bit 7
        logic     rsvd;   // bit 6, ignored
        reg_idx_t idx;    // bits 5..0
    } cmd_t;

    typedef struct packed {
        logic     valid;
        logic     write;
        reg_idx_t idx;
        data_t    wdata;
    } reg_req_t;

    typedef struct packed {
        logic  valid;
        data_t rdata;
    } reg_resp_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CMD,
        ST_DATA
    } frame_state_t;

    localparam int FRAME_BITS = 40;  // command byte + data word
    localparam int CMD_BITS   = 8;

    localparam data_t HW_ID = 32'hcafecafe;

    // register map
    localparam reg_idx_t IDX_HWID      = 6'd0;
    localparam reg_idx_t IDX_SCRATCH0  = 6'd1;
    localparam reg_idx_t IDX_SCRATCH1  = 6'd2;
    localparam reg_idx_t IDX_SCRATCH2  = 6'd3;
    localparam reg_idx_t IDX_UART_CTRL = 6'd4;
    localparam reg_idx_t IDX_GPIO      = 6'd5;
    localparam reg_idx_t IDX_GPIO_DIR  = 6'd6;

endpackage

//--- logic/spi_pin_sync.sv
// brings the spi pins into the w_clk domain
// sclk edges come out as one-cycle strobes, 3 cycles after the pin edge,
// and only while chip select is low
module spi_pin_sync (
    input  logic w_clk,
    input  logic i_nrst,
    input  logic i_csn,
    input  logic i_sclk,
    input  logic i_mosi,
    output logic o_csn,
    output logic o_mosi,
    output logic o_sclk_rise,
    output logic o_sclk_fall
);

    logic [1:0] csn_s;
    logic [1:0] mosi_s;
    logic [2:0] sclk_s;  // third stage for edge detect

    always_ff @(posedge w_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            csn_s       <= 2'b11;  // deselected
            mosi_s      <= 2'b00;
            sclk_s      <= 3'b000;  // mode 0 idles low
            o_sclk_rise <= 1'b0;
            o_sclk_fall <= 1'b0;
        end else begin
            csn_s  <= {csn_s[0], i_csn};
            mosi_s <= {mosi_s[0], i_mosi};
            sclk_s <= {sclk_s[1:0], i_sclk};
            o_sclk_rise <= sclk_s[1] & ~sclk_s[2] & ~csn_s[1];
            o_sclk_fall <= ~sclk_s[1] & sclk_s[2] & ~csn_s[1];
        end
    end

    assign o_csn  = csn_s[1];
    assign o_mosi = mosi_s[1];

endmodule

//--- logic/spi_frame_engine.sv
// spi slave frame engine, mode 0, msb first
// a frame is a command byte followed by a 32-bit data word; reads are
// requested right after the command byte, writes after the last bit.
// works only on the sclk strobes coming from the pin synchronizer
module spi_frame_engine (
    input  logic                  w_clk,
    input  logic                  i_nrst,
    input  logic                  i_csn,
    input  logic                  i_mosi,
    input  logic                  i_sclk_rise,
    input  logic                  i_sclk_fall,
    output logic                  o_miso,
    output spi_dev_pkg::reg_req_t o_req,
    input  spi_dev_pkg::reg_resp_t i_resp
);

    spi_dev_pkg::frame_state_t state;
    spi_dev_pkg::bit_cnt_t     bit_cnt;
    spi_dev_pkg::cmd_t         cmd_q;
    spi_dev_pkg::data_t        shift_in;
    spi_dev_pkg::data_t        shift_out;
    logic                      req_valid;
    logic                      miso_q;
    logic                      cmd_done;
    logic                      frame_done;

    // last bit of the command byte / of the frame on this rising strobe
    assign cmd_done = (state == spi_dev_pkg::ST_CMD) && i_sclk_rise &&
                      (bit_cnt == spi_dev_pkg::bit_cnt_t'(spi_dev_pkg::CMD_BITS - 1));
    assign frame_done = (state == spi_dev_pkg::ST_DATA) && i_sclk_rise &&
                        (bit_cnt == spi_dev_pkg::bit_cnt_t'(spi_dev_pkg::FRAME_BITS - 1));

    always_ff @(posedge w_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state     <= spi_dev_pkg::ST_IDLE;
            bit_cnt   <= '0;
            req_valid <= 1'b0;
            miso_q    <= 1'b0;
        end else begin
            req_valid <= 1'b0;  // one-cycle strobe
            if (i_csn) begin
                // deselect drops whatever is in flight
                state   <= spi_dev_pkg::ST_IDLE;
                bit_cnt <= '0;
                miso_q  <= 1'b0;
            end else begin
                case (state)
                    spi_dev_pkg::ST_IDLE: begin
                        state   <= spi_dev_pkg::ST_CMD;
                        bit_cnt <= '0;
                    end
                    spi_dev_pkg::ST_CMD: begin
                        if (i_sclk_rise) begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                        if (cmd_done) begin
                            state     <= spi_dev_pkg::ST_DATA;
                            req_valid <= ~shift_in[6];  // write flag went in first
                        end
                    end
                    spi_dev_pkg::ST_DATA: begin
                        // counter stops at the frame end, extra clocks ignored
                        if (i_sclk_rise &&
                            bit_cnt != spi_dev_pkg::bit_cnt_t'(spi_dev_pkg::FRAME_BITS)) begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                        if (frame_done) begin
                            req_valid <= cmd_q.write;
                        end
                        if (i_sclk_fall) begin
                            miso_q <= shift_out[31];
                        end
                    end
                    default: begin
                        state <= spi_dev_pkg::ST_IDLE;
                    end
                endcase
            end
        end
    end

    // data path
    always_ff @(posedge w_clk) begin
        if (i_sclk_rise) begin
            shift_in <= {shift_in[30:0], i_mosi};
        end
        if (cmd_done) begin
            cmd_q <= {shift_in[6:0], i_mosi};
        end
        if (i_resp.valid) begin
            shift_out <= i_resp.rdata;  // lands before the next falling strobe
        end else if (state == spi_dev_pkg::ST_DATA && i_sclk_fall) begin
            shift_out <= {shift_out[30:0], 1'b0};
        end
    end

    // wdata is the full word on the cycle after the 40th bit
    assign o_req = '{valid: req_valid,
                     write: cmd_q.write,
                     idx:   cmd_q.idx,
                     wdata: shift_in};

    assign o_miso = miso_q;

endmodule

//--- logic/spi_reg_block.sv
// register map served by the spi frame engine
// answers every request on the next cycle with the value held before the
// write; unmapped indices read as zero and drop writes
module spi_reg_block (
    input  logic                   w_clk,
    input  logic                   i_nrst,
    input  spi_dev_pkg::reg_req_t  i_req,
    output spi_dev_pkg::reg_resp_t o_resp,
    input  spi_dev_pkg::gpio_t     i_gpio_in,
    output spi_dev_pkg::gpio_t     o_gpio_out,
    output spi_dev_pkg::gpio_t     o_gpio_dir,
    output logic                   o_uart_loopback_ena
);

    spi_dev_pkg::data_t scratch0;
    spi_dev_pkg::data_t scratch1;
    spi_dev_pkg::data_t scratch2;
    spi_dev_pkg::gpio_t gpio_out;
    spi_dev_pkg::gpio_t gpio_dir;  // 1 = output
    logic               loopback;
    logic               resp_valid;
    spi_dev_pkg::data_t resp_rdata;
    spi_dev_pkg::data_t rdata;
    logic               wr_en;

    assign wr_en = i_req.valid & i_req.write;

    // read decode
    always_comb begin
        rdata = '0;
        case (i_req.idx)
            spi_dev_pkg::IDX_HWID:      rdata = spi_dev_pkg::HW_ID;
            spi_dev_pkg::IDX_SCRATCH0:  rdata = scratch0;
            spi_dev_pkg::IDX_SCRATCH1:  rdata = scratch1;
            spi_dev_pkg::IDX_SCRATCH2:  rdata = scratch2;
            spi_dev_pkg::IDX_UART_CTRL: rdata[0] = loopback;
            spi_dev_pkg::IDX_GPIO:      rdata[15:0] = i_gpio_in;  // pin levels, not gpio_out
            spi_dev_pkg::IDX_GPIO_DIR:  rdata[15:0] = gpio_dir;
            default:                    rdata = '0;
        endcase
    end

    always_ff @(posedge w_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            scratch0   <= '0;
            scratch1   <= '0;
            scratch2   <= '0;
            gpio_out   <= '0;
            gpio_dir   <= '0;  // all pins inputs
            loopback   <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= i_req.valid;
            if (wr_en) begin
                case (i_req.idx)
                    spi_dev_pkg::IDX_SCRATCH0:  scratch0 <= i_req.wdata;
                    spi_dev_pkg::IDX_SCRATCH1:  scratch1 <= i_req.wdata;
                    spi_dev_pkg::IDX_SCRATCH2:  scratch2 <= i_req.wdata;
                    spi_dev_pkg::IDX_UART_CTRL: loopback <= i_req.wdata[0];
                    spi_dev_pkg::IDX_GPIO:      gpio_out <= i_req.wdata[15:0];
                    spi_dev_pkg::IDX_GPIO_DIR:  gpio_dir <= i_req.wdata[15:0];
                    default: begin
                        // hwid and unmapped: nothing to write
                    end
                endcase
            end
        end
    end

    always_ff @(posedge w_clk) begin
        if (i_req.valid) begin
            resp_rdata <= rdata;
        end
    end

    assign o_resp = '{valid: resp_valid, rdata: resp_rdata};

    assign o_gpio_out          = gpio_out;
    assign o_gpio_dir          = gpio_dir;
    assign o_uart_loopback_ena = loopback;

endmodule

//--- logic/gpio_port.sv
// pad side of the 16 gpio pins
// drives pins whose direction bit is set, floats the rest, and brings
// every pin level back through a two-stage synchronizer
module gpio_port (
    input  logic               w_clk,
    input  logic               i_nrst,
    input  spi_dev_pkg::gpio_t i_gpio_out,
    input  spi_dev_pkg::gpio_t i_gpio_dir,
    output spi_dev_pkg::gpio_t o_gpio_in,
    inout  spi_dev_pkg::gpio_t io_gpio
);

    spi_dev_pkg::gpio_t sync_s1;
    spi_dev_pkg::gpio_t sync_s2;

    for (genvar i = 0; i < $bits(spi_dev_pkg::gpio_t); i++) begin : g_pad
        assign io_gpio[i] = i_gpio_dir[i] ? i_gpio_out[i] : 1'bz;
    end

    always_ff @(posedge w_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            sync_s1 <= '0;
            sync_s2 <= '0;
        end else begin
            sync_s1 <= io_gpio;  // output pins read back their own drive
            sync_s2 <= sync_s1;
        end
    end

    assign o_gpio_in = sync_s2;

endmodule

//--- logic/spi_dev_top.sv
// top of the spi device-test block
// spi pins in, register map behind them, gpio pads and uart loopback out.
// w_clk must run at least 8x the sclk rate
module spi_dev_top (
    input  logic               w_clk,
    input  logic               i_nrst,
    input  logic               i_csn,
    input  logic               i_sclk,
    input  logic               i_mosi,
    output logic               o_miso,
    output logic               o_uart_loopback_ena,
    inout  spi_dev_pkg::gpio_t io_gpio
);

    logic                   csn_sync;
    logic                   mosi_sync;
    logic                   sclk_rise;
    logic                   sclk_fall;
    spi_dev_pkg::reg_req_t  req;
    spi_dev_pkg::reg_resp_t resp;
    spi_dev_pkg::gpio_t     gpio_in;
    spi_dev_pkg::gpio_t     gpio_out;
    spi_dev_pkg::gpio_t     gpio_dir;

    spi_pin_sync u_pin_sync (
        .w_clk       (w_clk),
        .i_nrst      (i_nrst),
        .i_csn       (i_csn),
        .i_sclk      (i_sclk),
        .i_mosi      (i_mosi),
        .o_csn       (csn_sync),
        .o_mosi      (mosi_sync),
        .o_sclk_rise (sclk_rise),
        .o_sclk_fall (sclk_fall)
    );

    spi_frame_engine u_frame (
        .w_clk       (w_clk),
        .i_nrst      (i_nrst),
        .i_csn       (csn_sync),
        .i_mosi      (mosi_sync),
        .i_sclk_rise (sclk_rise),
        .i_sclk_fall (sclk_fall),
        .o_miso      (o_miso),
        .o_req       (req),
        .i_resp      (resp)
    );

    spi_reg_block u_regs (
        .w_clk               (w_clk),
        .i_nrst              (i_nrst),
        .i_req               (req),
        .o_resp              (resp),
        .i_gpio_in           (gpio_in),
        .o_gpio_out          (gpio_out),
        .o_gpio_dir          (gpio_dir),
        .o_uart_loopback_ena (o_uart_loopback_ena)
    );

    gpio_port u_gpio (
        .w_clk      (w_clk),
        .i_nrst     (i_nrst),
        .i_gpio_out (gpio_out),
        .i_gpio_dir (gpio_dir),
        .o_gpio_in  (gpio_in),
        .io_gpio    (io_gpio)
    );

endmodule

//--- tb/tb_spi_dev.sv
// testbench for the spi device-test block
// reads one test per line from tb/spi_dev_tests.txt, runs each as an spi
// frame (or a pin check) and compares against the file and a small model
// of the direction, gpio output and loopback registers
module tb_spi_dev;

    localparam int HALF   = 4;      // sclk half period in w_clk cycles
    localparam int MARGIN = 40000;  // watchdog slack in time units

    logic       w_clk;
    logic       nrst;
    logic       csn;
    logic       sclk;
    logic       mosi;
    wire        miso;
    wire        loopback;
    wire [15:0] gpio_pins;

    spi_dev_pkg::gpio_t pin_val;  // pattern for tb-driven pins
    spi_dev_pkg::gpio_t pin_oe;   // 1 = tb drives the pin

    // expected register state from the writes seen so far
    spi_dev_pkg::gpio_t dir_m;
    spi_dev_pkg::gpio_t out_m;
    logic               loop_m;

    logic [7:0]              op_q[$];
    spi_dev_pkg::reg_idx_t   idx_q[$];
    spi_dev_pkg::data_t      val_q[$];
    spi_dev_pkg::gpio_t      pin_q[$];
    bit                      tests_loaded = 1'b0;

    spi_dev_top dut (
        .w_clk               (w_clk),
        .i_nrst              (nrst),
        .i_csn               (csn),
        .i_sclk              (sclk),
        .i_mosi              (mosi),
        .o_miso              (miso),
        .o_uart_loopback_ena (loopback),
        .io_gpio             (gpio_pins)
    );

    for (genvar i = 0; i < 16; i++) begin : g_pin
        assign gpio_pins[i] = pin_oe[i] ? pin_val[i] : 1'bz;
    end

    initial begin
        w_clk = 1'b0;
        forever #4 w_clk = ~w_clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic load_tests();
        int         fd;
        int         n;
        string      text;
        logic [7:0] op;
        logic [31:0] idx;
        logic [31:0] val;
        logic [31:0] pins;
        fd = $fopen("tb/spi_dev_tests.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the test file tb/spi_dev_tests.txt");
        end
        while (!$feof(fd)) begin
            text = "";
            n = $fgets(text, fd);
            if (text.len() == 0 || text[0] == "#") begin
                continue;  // header or empty line
            end
            n = $sscanf(text, "%c %h %h %h", op, idx, val, pins);
            if (n == 4) begin
                op_q.push_back(op);
                idx_q.push_back(idx[5:0]);
                val_q.push_back(val);
                pin_q.push_back(pins[15:0]);
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_pins(input spi_dev_pkg::gpio_t pattern, input spi_dev_pkg::gpio_t mask);
        @(posedge w_clk);
        pin_val <= pattern;
        pin_oe  <= mask;
    endtask

    // mode 0 master sending msb first
    // nbits below 40 cuts the frame short
    task automatic spi_frame(input logic [39:0] frame, input int nbits,
                             output spi_dev_pkg::data_t rdata);
        int i;
        rdata = '0;
        @(posedge w_clk);
        csn  <= 1'b0;
        sclk <= 1'b0;
        for (i = 0; i < nbits; i++) begin
            mosi <= frame[39 - i];  // changes with the falling edge
            repeat (HALF) @(posedge w_clk);
            sclk <= 1'b1;
            // miso trails the falling edge by 4 clocks through the pin sync
            @(negedge w_clk);
            if (i >= spi_dev_pkg::CMD_BITS) begin
                rdata = {rdata[30:0], miso};
            end
            repeat (HALF) @(posedge w_clk);
            sclk <= 1'b0;
        end
        repeat (HALF) @(posedge w_clk);
        csn <= 1'b1;
        repeat (2 * HALF) @(posedge w_clk);  // gap so the engine sees idle
    endtask

    task automatic run_test(input logic [7:0] op, input spi_dev_pkg::reg_idx_t idx,
                            input spi_dev_pkg::data_t val, input spi_dev_pkg::gpio_t pins);
        spi_dev_pkg::data_t rd;
        spi_dev_pkg::gpio_t new_dir;
        new_dir = dir_m;
        if (op == "W" && idx == spi_dev_pkg::IDX_GPIO_DIR) begin
            new_dir = val[15:0];
        end
        // release pins that are about to become outputs
        drive_pins(pins, ~(dir_m | new_dir));
        case (op)
            "W": begin
                spi_frame({2'b10, idx, val}, spi_dev_pkg::FRAME_BITS, rd);
                if (idx == spi_dev_pkg::IDX_UART_CTRL) loop_m = val[0];
                if (idx == spi_dev_pkg::IDX_GPIO) out_m = val[15:0];
                if (idx == spi_dev_pkg::IDX_GPIO_DIR) dir_m = val[15:0];
            end
            "C": spi_frame({2'b10, idx, val}, 20, rd);  // write dropped
            "R": begin
                spi_frame({2'b00, idx, 32'h0}, spi_dev_pkg::FRAME_BITS, rd);
                check_value($sformatf("rdata[idx %0h]", idx), rd, val);
            end
            "P": begin
                repeat (4) @(posedge w_clk);
                @(negedge w_clk);
                check_value("io_gpio", 32'(gpio_pins), val);
            end
            default: abort_run($sformatf("unknown operation %c in the test file", op));
        endcase
        drive_pins(pins, ~dir_m);
        @(negedge w_clk);
        check_value("o_uart_loopback_ena", 32'(loopback), 32'(loop_m));
        check_value("io_gpio outputs", 32'(gpio_pins & dir_m), 32'(out_m & dir_m));
    endtask

    // watchdog sized from the number of frames in the file
    initial begin
        longint limit;
        wait (tests_loaded);
        limit = longint'(op_q.size()) * spi_dev_pkg::FRAME_BITS * 8 * 8 + MARGIN;
        #(limit);
        abort_run("timeout: the tests did not finish in the allowed time");
    end

    initial begin
        int t;
        nrst    = 1'b0;
        csn     = 1'b1;
        sclk    = 1'b0;
        mosi    = 1'b0;
        pin_val = '0;
        pin_oe  = '1;  // all pins inputs after reset
        dir_m   = '0;
        out_m   = '0;
        loop_m  = 1'b0;
        load_tests();
        tests_loaded = 1'b1;
        repeat (8) @(posedge w_clk);
        nrst <= 1'b1;
        repeat (4) @(posedge w_clk);
        for (t = 0; t < op_q.size(); t++) begin
            run_test(op_q[t], idx_q[t], val_q[t], pin_q[t]);
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- tb/spi_dev_tests.txt
# op idx value pins, all hex; W write, R read and compare, P compare io_gpio levels,
# C write cut after 20 bits; pins is the pattern driven on gpio input pins
R 00 cafecafe 0000
R 01 00000000 0000
R 02 00000000 0000
R 03 00000000 0000
R 04 00000000 0000
R 05 00000000 0000
R 06 00000000 0000
W 01 12345678 0000
W 02 9abcdef0 0000
W 03 0badf00d 0000
R 01 12345678 0000
R 02 9abcdef0 0000
R 03 0badf00d 0000
W 02 a5a5a5a5 0000
R 01 12345678 0000
R 02 a5a5a5a5 0000
R 03 0badf00d 0000
W 04 ffffffff 0000
R 04 00000001 0000
W 04 fffffffe 0000
R 04 00000000 0000
W 04 00000001 0000
W 05 0000c3a5 0000
R 05 00001234 1234
W 06 000000ff 1234
P 00 000012a5 1234
R 05 000012a5 1234
R 06 000000ff 1234
R 05 0000eda5 edff
W 05 ffff003c edff
R 05 0000ed3c edff
W 06 0000f00f 0550
P 00 0000055c 0550
R 05 0000055c 0550
R 06 0000f00f 0550
W 06 00000000 0000
P 00 00000000 0000
R 05 0000beef beef
W 09 deadbeef 0000
R 09 00000000 0000
W 3f ffffffff 0000
R 3f 00000000 0000
W 00 00000000 0000
R 00 cafecafe 0000
R 01 12345678 0000
R 02 a5a5a5a5 0000
C 01 ffffffff 0000
R 01 12345678 0000
C 03 00000000 0000
R 03 0badf00d 0000
W 04 00000000 0000
R 04 00000000 0000

//--- flist.f
logic/spi_dev_pkg.sv
logic/spi_pin_sync.sv
logic/spi_frame_engine.sv
logic/spi_reg_block.sv
logic/gpio_port.sv
logic/spi_dev_top.sv
tb/tb_spi_dev.sv
